/* Bender.yml */
package:
  name: side_ch_iq

sources:
  - side_ch_data_pkg.sv
  - side_ch_ctrl_pkg.sv
  - iq_trigger_detect.sv
  - iq_ring_buffer.sv
  - iq_capture_seq.sv
  - dma_start_ctrl.sv
  - side_ch_iq_top.sv
  - target: simulation
    files:
      - side_ch_sva.sv
      - tb_side_ch.sv

/* all.f */
side_ch_data_pkg.sv
side_ch_ctrl_pkg.sv
iq_trigger_detect.sv
iq_ring_buffer.sv
iq_capture_seq.sv
dma_start_ctrl.sv
side_ch_iq_top.sv
side_ch_sva.sv
tb_side_ch.sv

/* dma_start_ctrl.sv */
// dma start pulse from a length register write or an external trigger, and output gating by mode
`timescale 1ns/1ps

module dma_start_ctrl (
	input logic clk,
	input logic rstn,
	input side_ch_ctrl_pkg::start_mode_e start_mode,
	input logic slv_reg_wren_signal,
	input logic [side_ch_ctrl_pkg::REG_ADDR_WIDTH-1:0] axi_awaddr_core,
	input logic m_axis_start_ext_trigger,
	input side_ch_data_pkg::iq_word_t side_info,
	input logic side_info_valid,
	output logic m_axis_start_1trans,
	output side_ch_data_pkg::iq_word_t data_to_ps,
	output logic data_to_ps_valid
);
	import side_ch_ctrl_pkg::*;

	logic len_wr;
	logic len_wr_q;
	logic len_wr_q1;
	logic auto_start;
	logic mode_on;

	assign len_wr = slv_reg_wren_signal && (axi_awaddr_core == LEN_REG_ADDR);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			len_wr_q <= 1'b0;
			len_wr_q1 <= 1'b0;
			auto_start <= 1'b0;
		end else begin
			len_wr_q <= len_wr;
			len_wr_q1 <= len_wr_q;
			auto_start <= len_wr_q && !len_wr_q1; // first cycle of the write only
		end
	end

	always_comb begin
		case (start_mode)
			START_AUTO: m_axis_start_1trans = auto_start;
			START_EXT: m_axis_start_1trans = m_axis_start_ext_trigger;
			default: m_axis_start_1trans = 1'b0;
		endcase
	end

	assign mode_on = (start_mode == START_AUTO || start_mode == START_EXT);
	assign data_to_ps_valid = mode_on & side_info_valid;
	assign data_to_ps = mode_on ? side_info : '0;

endmodule

/* iq_capture_seq.sv */
// capture FSM: on trig rewinds into the ring buffer, checks dma room, sends tsf header then the words
`timescale 1ns/1ps

module iq_capture_seq (
	input logic clk,
	input logic rstn,
	input logic iq_capture,
	input logic trig,
	input logic iq_strobe,
	input logic [side_ch_data_pkg::IQ_ADDR_WIDTH-1:0] waddr,
	output logic [side_ch_data_pkg::IQ_ADDR_WIDTH-1:0] raddr,
	input side_ch_data_pkg::iq_word_t rd_word,
	input logic [side_ch_data_pkg::TSF_TIMER_WIDTH-1:0] tsf_runtime_val,
	input logic [side_ch_data_pkg::DMA_COUNT_WIDTH-1:0] pre_trigger_len,
	input logic [side_ch_data_pkg::DMA_COUNT_WIDTH-1:0] iq_len_target,
	input logic [side_ch_data_pkg::DMA_COUNT_WIDTH-1:0] m_axis_data_count,
	output side_ch_data_pkg::iq_word_t side_info,
	output logic side_info_valid
);
	import side_ch_data_pkg::*;
	import side_ch_ctrl_pkg::*;

	iq_state_e state;
	logic [IQ_ADDR_WIDTH-1:0] raddr_q;
	logic [IQ_ADDR_WIDTH-1:0] raddr_nxt;
	logic [DMA_COUNT_WIDTH-1:0] count;
	logic [TSF_TIMER_WIDTH-1:0] tsf_lock;
	logic [DMA_COUNT_WIDTH+1:0] words_needed;
	logic room_ok;
	logic accept;

	assign accept = iq_capture && (state == IQ_WAIT) && trig;

	// fifo fill plus header plus payload has to fit one udp datagram
	assign words_needed = {2'b00, m_axis_data_count} + {2'b00, iq_len_target} + 1'b1;
	assign room_ok = words_needed <= (DMA_COUNT_WIDTH+2)'(MAX_NUM_DMA_SYMBOL_UDP);

	// look-ahead address so rd_word already holds mem[raddr_q] on every cycle
	always_comb begin
		raddr_nxt = raddr_q;
		if (accept)
			raddr_nxt = waddr - pre_trigger_len[IQ_ADDR_WIDTH-1:0];
		else if (iq_capture && state == IQ_STREAM && iq_strobe)
			raddr_nxt = raddr_q + 1'b1;
	end
	assign raddr = raddr_nxt;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= IQ_WAIT;
			raddr_q <= '0;
			count <= '0;
		end else begin
			raddr_q <= raddr_nxt;
			if (!iq_capture) begin
				state <= IQ_WAIT;
			end else begin
				case (state)
					IQ_WAIT: begin
						count <= '0;
						if (trig)
							state <= IQ_PREPARE;
					end
					IQ_PREPARE: state <= room_ok ? IQ_HEADER : IQ_WAIT; // drop if no room
					IQ_HEADER: state <= (iq_len_target == '0) ? IQ_WAIT : IQ_STREAM;
					IQ_STREAM: begin
						if (iq_strobe) begin
							count <= count + 1'b1;
							if (count == iq_len_target - 1'b1)
								state <= IQ_WAIT;
						end
					end
					default: state <= IQ_WAIT;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			tsf_lock <= tsf_runtime_val;
	end

	always_comb begin
		side_info = rd_word;
		side_info_valid = 1'b0;
		if (iq_capture && state == IQ_HEADER) begin
			side_info = iq_word_t'(tsf_lock);
			side_info_valid = 1'b1;
		end else if (iq_capture && state == IQ_STREAM) begin
			side_info_valid = iq_strobe; // one word per source strobe
		end
	end

endmodule

/* iq_ring_buffer.sv */
// always-on IQ history: packs the selected source into words and writes them round a dual-port ram
`timescale 1ns/1ps

module iq_ring_buffer (
	input logic clk,
	input logic rstn,
	input logic iq_capture,
	input side_ch_ctrl_pkg::iq_source_e source_select,
	input logic pack_two_iq,
	input side_ch_data_pkg::iq_sample_t rx_iq0,
	input side_ch_data_pkg::iq_sample_t rx_iq1,
	input side_ch_data_pkg::iq_sample_t tx_iq0,
	input side_ch_data_pkg::iq_sample_t tx_iq1,
	input logic rx_strobe,
	input logic tx_strobe,
	input logic signed [side_ch_data_pkg::RSSI_HALF_DB_WIDTH-1:0] rssi_half_db,
	input side_ch_data_pkg::agc_status_t gpio_status,
	input logic [side_ch_data_pkg::IQ_ADDR_WIDTH-1:0] raddr,
	output logic [side_ch_data_pkg::IQ_ADDR_WIDTH-1:0] waddr,
	output logic iq_strobe,
	output side_ch_data_pkg::iq_word_t rd_word
);
	import side_ch_data_pkg::*;
	import side_ch_ctrl_pkg::*;

	iq_sample_t iq0;
	iq_sample_t iq1;
	iq_word_t wr_word;
	iq_word_t mem [IQ_BUF_DEPTH];

	assign iq0 = (source_select == SRC_TX_INTF) ? tx_iq0 : rx_iq0;
	assign iq1 = (source_select == SRC_TX_INTF) ? tx_iq1 : rx_iq1;
	assign iq_strobe = (source_select == SRC_TX_INTF) ? tx_strobe : rx_strobe;

	// status word: {pad, rssi, pad, gpio, iq0}
	assign wr_word.lo = iq0;
	assign wr_word.hi = pack_two_iq ? iq1 :
		{{(IQ_DATA_WIDTH-RSSI_HALF_DB_WIDTH){1'b0}}, rssi_half_db,
		{(IQ_DATA_WIDTH-GPIO_STATUS_WIDTH){1'b0}}, gpio_status};

	always_ff @(posedge clk) begin
		if (!rstn)
			waddr <= '0;
		else if (iq_capture && iq_strobe)
			waddr <= waddr + 1'b1; // wraps, oldest word is overwritten
	end

	always_ff @(posedge clk) begin
		if (iq_capture && iq_strobe)
			mem[waddr] <= wr_word;
		if (iq_capture)
			rd_word <= mem[raddr];
	end

endmodule

/* iq_trigger_detect.sv */
// picks one rx event (fcs, preamble, rssi, agc or gain edge) and turns it into a one-cycle trig pulse
`timescale 1ns/1ps

module iq_trigger_detect (
	input logic clk,
	input logic rstn,
	input logic iq_capture,
	input side_ch_ctrl_pkg::trigger_sel_e trigger_select,
	input logic free_run,
	input logic fcs_in_strobe,
	input logic fcs_ok,
	input logic long_preamble_detected,
	input logic short_preamble_detected,
	input logic signed [side_ch_data_pkg::RSSI_HALF_DB_WIDTH-1:0] rssi_half_db,
	input logic signed [side_ch_data_pkg::RSSI_HALF_DB_WIDTH-1:0] rssi_th,
	input side_ch_data_pkg::agc_status_t gpio_status,
	input logic [side_ch_data_pkg::GPIO_STATUS_WIDTH-2:0] gain_th,
	output logic trig
);
	import side_ch_data_pkg::*;
	import side_ch_ctrl_pkg::*;

	logic signed [RSSI_HALF_DB_WIDTH-1:0] rssi_q;
	agc_status_t gpio_q;
	logic rssi_rise;
	logic rssi_fall;
	logic agc_lock_to_unlock;
	logic agc_unlock_to_lock;
	logic gain_rise;
	logic gain_fall;
	logic trig_sel;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_q <= '0;
			gpio_q <= '0;
			rssi_rise <= 1'b0;
			rssi_fall <= 1'b0;
			agc_lock_to_unlock <= 1'b0;
			agc_unlock_to_lock <= 1'b0;
			gain_rise <= 1'b0;
			gain_fall <= 1'b0;
			trig <= 1'b0;
		end else begin
			trig <= iq_capture & trig_sel; // no stale pulse once capture stops
			if (iq_capture) begin
				rssi_q <= rssi_half_db;
				gpio_q <= gpio_status;
				rssi_rise <= (rssi_q < rssi_th) && (rssi_half_db >= rssi_th);
				rssi_fall <= (rssi_q >= rssi_th) && (rssi_half_db < rssi_th);
				agc_lock_to_unlock <= gpio_q.lock && !gpio_status.lock;
				agc_unlock_to_lock <= !gpio_q.lock && gpio_status.lock;
				gain_rise <= (gpio_q.gain < gain_th) && (gpio_status.gain >= gain_th);
				gain_fall <= (gpio_q.gain >= gain_th) && (gpio_status.gain < gain_th);
			end
		end
	end

	// strobes go straight in, level crossings come from the registered flags
	always_comb begin
		case (trigger_select)
			TRIG_FCS_OR_FREE: trig_sel = fcs_in_strobe | free_run;
			TRIG_FCS_OK: trig_sel = fcs_in_strobe & fcs_ok;
			TRIG_FCS_BAD: trig_sel = fcs_in_strobe & !fcs_ok;
			TRIG_LONG_PREAMBLE: trig_sel = long_preamble_detected;
			TRIG_SHORT_PREAMBLE: trig_sel = short_preamble_detected;
			TRIG_RSSI_RISE: trig_sel = rssi_rise;
			TRIG_RSSI_FALL: trig_sel = rssi_fall;
			TRIG_AGC_LOCK_TO_UNLOCK: trig_sel = agc_lock_to_unlock;
			TRIG_AGC_UNLOCK_TO_LOCK: trig_sel = agc_unlock_to_lock;
			TRIG_GAIN_RISE: trig_sel = gain_rise;
			TRIG_GAIN_FALL: trig_sel = gain_fall;
			default: trig_sel = fcs_in_strobe;
		endcase
	end

endmodule

/* side_ch_ctrl_pkg.sv */
// control encodings for the IQ capture path: trigger codes, sources, start modes, sequencer states
package side_ch_ctrl_pkg;

	// write to this register address kicks an auto start
	localparam int REG_ADDR_WIDTH = 5;
	localparam logic [REG_ADDR_WIDTH-1:0] LEN_REG_ADDR = 5'd2;

	// numbering kept from the full trigger map, gaps are unused codes
	typedef enum logic [4:0] {
		TRIG_FCS_OR_FREE = 5'd0,
		TRIG_FCS_OK = 5'd1,
		TRIG_FCS_BAD = 5'd2,
		TRIG_LONG_PREAMBLE = 5'd8,
		TRIG_SHORT_PREAMBLE = 5'd9,
		TRIG_RSSI_RISE = 5'd10,
		TRIG_RSSI_FALL = 5'd11,
		TRIG_AGC_LOCK_TO_UNLOCK = 5'd12,
		TRIG_AGC_UNLOCK_TO_LOCK = 5'd13,
		TRIG_GAIN_RISE = 5'd14,
		TRIG_GAIN_FALL = 5'd15
	} trigger_sel_e;

	typedef enum logic [1:0] {
		SRC_RX = 2'd0,
		SRC_TX_INTF = 2'd2
	} iq_source_e;

	// code 0 is treated as off as well
	typedef enum logic [1:0] {
		START_AUTO = 2'd1,
		START_EXT = 2'd2,
		START_OFF = 2'd3
	} start_mode_e;

	typedef enum logic [1:0] {
		IQ_WAIT = 2'd0,
		IQ_PREPARE = 2'd1,
		IQ_HEADER = 2'd2,
		IQ_STREAM = 2'd3
	} iq_state_e;

endpackage

/* side_ch_data_pkg.sv */
// sample, word and status types plus buffer sizes, shared by every stage of the IQ capture path
package side_ch_data_pkg;

	localparam int IQ_DATA_WIDTH = 16;
	localparam int RSSI_HALF_DB_WIDTH = 11; // signed, half dB steps
	localparam int GPIO_STATUS_WIDTH = 8; // lock bit on top, gain below
	localparam int TSF_TIMER_WIDTH = 64;
	localparam int DMA_DATA_WIDTH = 64;

	localparam int IQ_ADDR_WIDTH = 10;
	localparam int IQ_BUF_DEPTH = 1 << IQ_ADDR_WIDTH;

	localparam int DMA_COUNT_WIDTH = 14;
	// 65507 byte UDP payload / 8 bytes per word
	localparam int MAX_NUM_DMA_SYMBOL_UDP = 8188;

	typedef struct packed {
		logic signed [IQ_DATA_WIDTH-1:0] i;
		logic signed [IQ_DATA_WIDTH-1:0] q;
	} iq_sample_t;

	// upper half is either the second sample or rssi and gpio status
	typedef struct packed {
		logic [DMA_DATA_WIDTH/2-1:0] hi;
		iq_sample_t lo;
	} iq_word_t;

	typedef struct packed {
		logic lock;
		logic [GPIO_STATUS_WIDTH-2:0] gain;
	} agc_status_t;

endpackage

/* side_ch_iq_top.sv */
// IQ capture side channel top: trigger detect, ring buffer, capture sequencer and dma output in a row
`timescale 1ns/1ps

module side_ch_iq_top (
	input logic clk,
	input logic rstn,
	input logic iq_capture,
	input side_ch_ctrl_pkg::trigger_sel_e trigger_select,
	input logic free_run,
	input logic fcs_in_strobe,
	input logic fcs_ok,
	input logic long_preamble_detected,
	input logic short_preamble_detected,
	input logic signed [side_ch_data_pkg::RSSI_HALF_DB_WIDTH-1:0] rssi_half_db,
	input logic signed [side_ch_data_pkg::RSSI_HALF_DB_WIDTH-1:0] rssi_th,
	input side_ch_data_pkg::agc_status_t gpio_status,
	input logic [side_ch_data_pkg::GPIO_STATUS_WIDTH-2:0] gain_th,
	input side_ch_ctrl_pkg::iq_source_e source_select,
	input logic pack_two_iq,
	input side_ch_data_pkg::iq_sample_t rx_iq0,
	input side_ch_data_pkg::iq_sample_t rx_iq1,
	input side_ch_data_pkg::iq_sample_t tx_iq0,
	input side_ch_data_pkg::iq_sample_t tx_iq1,
	input logic rx_strobe,
	input logic tx_strobe,
	input logic [side_ch_data_pkg::TSF_TIMER_WIDTH-1:0] tsf_runtime_val,
	input logic [side_ch_data_pkg::DMA_COUNT_WIDTH-1:0] pre_trigger_len,
	input logic [side_ch_data_pkg::DMA_COUNT_WIDTH-1:0] iq_len_target,
	input logic [side_ch_data_pkg::DMA_COUNT_WIDTH-1:0] m_axis_data_count,
	input side_ch_ctrl_pkg::start_mode_e start_mode,
	input logic slv_reg_wren_signal,
	input logic [side_ch_ctrl_pkg::REG_ADDR_WIDTH-1:0] axi_awaddr_core,
	input logic m_axis_start_ext_trigger,
	output logic m_axis_start_1trans,
	output side_ch_data_pkg::iq_word_t data_to_ps,
	output logic data_to_ps_valid
);
	import side_ch_data_pkg::*;

	logic trig;
	logic iq_strobe;
	logic [IQ_ADDR_WIDTH-1:0] waddr;
	logic [IQ_ADDR_WIDTH-1:0] raddr;
	iq_word_t rd_word;
	iq_word_t side_info;
	logic side_info_valid;

	iq_trigger_detect u_trigger_detect (
		.clk, .rstn, .iq_capture, .trigger_select, .free_run,
		.fcs_in_strobe, .fcs_ok, .long_preamble_detected, .short_preamble_detected,
		.rssi_half_db, .rssi_th, .gpio_status, .gain_th, .trig
	);

	iq_ring_buffer u_ring_buffer (
		.clk, .rstn, .iq_capture, .source_select, .pack_two_iq,
		.rx_iq0, .rx_iq1, .tx_iq0, .tx_iq1, .rx_strobe, .tx_strobe,
		.rssi_half_db, .gpio_status, .raddr, .waddr, .iq_strobe, .rd_word
	);

	iq_capture_seq u_capture_seq (
		.clk, .rstn, .iq_capture, .trig, .iq_strobe, .waddr, .raddr, .rd_word,
		.tsf_runtime_val, .pre_trigger_len, .iq_len_target, .m_axis_data_count,
		.side_info, .side_info_valid
	);

	dma_start_ctrl u_dma_start (
		.clk, .rstn, .start_mode, .slv_reg_wren_signal, .axi_awaddr_core,
		.m_axis_start_ext_trigger, .side_info, .side_info_valid,
		.m_axis_start_1trans, .data_to_ps, .data_to_ps_valid
	);

endmodule

/* side_ch_sva.sv */
// concurrent checks on the capture FSM and its valid output for binding into iq_capture_seq
`timescale 1ns/1ps

module side_ch_sva (
	input logic clk,
	input logic rstn,
	input side_ch_ctrl_pkg::iq_state_e state,
	input logic side_info_valid
);
	import side_ch_ctrl_pkg::*;

	int fail_count = 0;

	// idle FSM keeps the stream quiet
	no_valid_in_wait: assert property (@(posedge clk) disable iff (!rstn)
		state == IQ_WAIT |-> !side_info_valid)
		else begin
			fail_count++;
			$error("side_info_valid high while the sequencer is in IQ_WAIT");
		end

	header_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
		state == IQ_HEADER |=> state != IQ_HEADER)
		else begin
			fail_count++;
			$error("IQ_HEADER held for more than one cycle");
		end

	prepare_exit: assert property (@(posedge clk) disable iff (!rstn)
		state == IQ_PREPARE |=> state inside {IQ_HEADER, IQ_WAIT})
		else begin
			fail_count++;
			$error("IQ_PREPARE left to a state other than IQ_HEADER or IQ_WAIT");
		end

endmodule

bind iq_capture_seq side_ch_sva u_sva (
	.clk(clk),
	.rstn(rstn),
	.state(state),
	.side_info_valid(side_info_valid)
);

/* tb_side_ch.sv */
// testbench for the IQ capture side channel that drives samples and events and checks the dma words
`timescale 1ns/1ps

module tb_side_ch;
	import side_ch_data_pkg::*;
	import side_ch_ctrl_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int N_CAPTURES = 10; // captures that reach data_to_ps over all tests
	localparam int MAX_LEN = 24;
	localparam int FIXED_CYCLES = 400; // reset, preload and idle stretches
	localparam int WATCHDOG_CYCLES = FIXED_CYCLES + N_CAPTURES * (4 * MAX_LEN + 40);
	localparam logic [63:0] TSF_BASE = 64'h0000_0042_0000_0000;

	typedef struct packed {
		iq_sample_t iq0;
		iq_sample_t iq1;
		logic signed [RSSI_HALF_DB_WIDTH-1:0] rssi;
		agc_status_t gpio;
		logic two; // packing mode at write time
	} rec_t;

	logic clk = 1'b0;
	logic rstn, iq_capture, free_run, fcs_in_strobe, fcs_ok;
	logic long_preamble_detected, short_preamble_detected, pack_two_iq;
	logic rx_strobe, tx_strobe, slv_reg_wren_signal, m_axis_start_ext_trigger;
	logic m_axis_start_1trans, data_to_ps_valid;
	trigger_sel_e trigger_select;
	logic signed [RSSI_HALF_DB_WIDTH-1:0] rssi_half_db, rssi_th;
	agc_status_t gpio_status;
	logic [GPIO_STATUS_WIDTH-2:0] gain_th;
	iq_source_e source_select;
	iq_sample_t rx_iq0, rx_iq1, tx_iq0, tx_iq1;
	logic [TSF_TIMER_WIDTH-1:0] tsf_runtime_val;
	logic [DMA_COUNT_WIDTH-1:0] pre_trigger_len, iq_len_target, m_axis_data_count;
	start_mode_e start_mode;
	logic [REG_ADDR_WIDTH-1:0] axi_awaddr_core;
	iq_word_t data_to_ps;

	rec_t rec_q[$]; // every word the ring buffer took in write order
	logic [63:0] exp_q[$];
	int cyc = 0;
	int acc_cyc = -1; // predicted trigger acceptance cycle
	int stream_from = 0;
	int remaining = 0;
	int fr_left = 0;
	int errors = 0;

	side_ch_iq_top dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
			$display("sim failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	function automatic logic [63:0] ref_word(input rec_t r);
		if (r.two)
			return {r.iq1, r.iq0};
		return {5'd0, r.rssi, 8'd0, r.gpio, r.iq0}; // rssi and agc status beside iq0
	endfunction

	// header with the tsf at acceptance then the window that starts pre_trigger_len back
	function automatic void expect_capture(input logic [63:0] tsf);
		int first;
		int k;
		first = rec_q.size() - int'(pre_trigger_len);
		exp_q.push_back(tsf);
		for (k = 0; k < int'(iq_len_target); k++)
			exp_q.push_back(ref_word(rec_q[first + k]));
	endfunction

	function automatic rec_t held_sample();
		if (source_select == SRC_TX_INTF)
			return {tx_iq0, tx_iq1, rssi_half_db, gpio_status, pack_two_iq};
		return {rx_iq0, rx_iq1, rssi_half_db, gpio_status, pack_two_iq};
	endfunction

	function automatic logic gap_strobe();
		return ($urandom % 4) != 0;
	endfunction

	task automatic tick(input logic strb);
		@(posedge clk);
		#1;
		// the edge just passed wrote the inputs held through the last cycle
		if (iq_capture && ((source_select == SRC_TX_INTF) ? tx_strobe : rx_strobe))
			rec_q.push_back(held_sample());
		tsf_runtime_val = TSF_BASE + 64'(cyc);
		if (cyc == acc_cyc) begin
			expect_capture(tsf_runtime_val);
			remaining = int'(iq_len_target);
			stream_from = cyc + 3; // prepare and header first
		end
		rx_iq0 = $urandom;
		rx_iq1 = $urandom;
		tx_iq0 = $urandom;
		tx_iq1 = $urandom;
		rx_strobe = (source_select == SRC_TX_INTF) ? 1'($urandom) : strb;
		tx_strobe = (source_select == SRC_TX_INTF) ? strb : 1'($urandom);
		if (remaining > 0 && cyc >= stream_from && strb) begin
			remaining--;
			if (remaining == 0 && fr_left > 0) begin
				fr_left--;
				if (fr_left > 0)
					acc_cyc = cyc + 1; // free run fires again in the first idle cycle
				else
					free_run = 1'b0;
			end
		end
	endtask

	task automatic run(input int n);
		repeat (n) tick(gap_strobe());
	endtask

	task automatic fcs_event(input logic ok, input logic capture_expected);
		tick(gap_strobe());
		fcs_in_strobe = 1'b1;
		fcs_ok = ok;
		if (capture_expected)
			acc_cyc = cyc + 1;
		tick(gap_strobe());
		fcs_in_strobe = 1'b0;
	endtask

	task automatic wait_done();
		while (acc_cyc >= cyc || remaining > 0 || exp_q.size() > 0)
			tick(gap_strobe());
	endtask

	// three cycle register write with the pulse due on its third cycle only
	task automatic start_pulse_check(input logic pulse_expected);
		int k;
		for (k = 0; k < 6; k++) begin
			tick(gap_strobe());
			slv_reg_wren_signal = (k < 3);
			@(negedge clk);
			compare("m_axis_start_1trans", m_axis_start_1trans, pulse_expected && k == 2);
		end
	endtask

	always @(negedge clk) begin
		if (rstn && start_mode == START_OFF)
			compare("data_to_ps", data_to_ps, 64'd0);
		if (rstn && data_to_ps_valid) begin
			if (exp_q.size() == 0)
				compare("data_to_ps_valid", data_to_ps_valid, 1'b0);
			else
				compare("data_to_ps", data_to_ps, exp_q.pop_front());
		end
	end

	always @(negedge clk) begin
		if (dut.u_capture_seq.u_sva.fail_count != 0) begin
			$display("an assertion on the capture sequencer failed");
			$display("sim failed");
			$fatal(1, "assertion failure");
		end
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("watchdog expired after %0d cycles, the DUT stream never completed",
			WATCHDOG_CYCLES);
		$display("sim failed");
		$fatal(1, "run aborted");
	end

	initial begin
		void'($urandom(79));
		rstn = 1'b0;
		iq_capture = 1'b1;
		free_run = 1'b0;
		fcs_in_strobe = 1'b0;
		fcs_ok = 1'b0;
		long_preamble_detected = 1'b0;
		short_preamble_detected = 1'b0;
		pack_two_iq = 1'b1;
		rx_strobe = 1'b0;
		tx_strobe = 1'b0;
		slv_reg_wren_signal = 1'b0;
		m_axis_start_ext_trigger = 1'b0;
		trigger_select = TRIG_FCS_OK;
		rssi_half_db = 11'sd50;
		rssi_th = 11'sd100;
		gpio_status = '{lock: 1'b1, gain: 7'd40};
		gain_th = 7'd64;
		source_select = SRC_RX;
		rx_iq0 = '0;
		rx_iq1 = '0;
		tx_iq0 = '0;
		tx_iq1 = '0;
		tsf_runtime_val = '0;
		pre_trigger_len = 14'd16;
		iq_len_target = 14'd16;
		m_axis_data_count = '0;
		start_mode = START_EXT;
		axi_awaddr_core = LEN_REG_ADDR;
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;
		@(negedge clk);
		compare("data_to_ps_valid", data_to_ps_valid, 1'b0);
		compare("m_axis_start_1trans", m_axis_start_1trans, 1'b0);
		repeat (64) tick(1'b1);

		// fcs ok with two samples per word and gapped rx strobes
		fcs_event(1'b0, 1'b0); // bad fcs does not fire
		fcs_event(1'b1, 1'b1);
		wait_done();
		pre_trigger_len = 14'd24;
		iq_len_target = 14'd12;
		fcs_event(1'b1, 1'b1);
		wait_done();

		// three back to back free run captures
		trigger_select = TRIG_FCS_OR_FREE;
		pre_trigger_len = 14'd8;
		iq_len_target = 14'd8;
		tick(gap_strobe());
		free_run = 1'b1;
		fr_left = 3;
		acc_cyc = cyc + 1;
		wait_done();

		// rssi and agc edges with status words
		pack_two_iq = 1'b0;
		pre_trigger_len = 14'd12;
		iq_len_target = 14'd12;
		trigger_select = TRIG_RSSI_RISE;
		tick(gap_strobe());
		rssi_half_db = 11'sd90; // still below threshold
		run(8);
		rssi_half_db = 11'sd150;
		acc_cyc = cyc + 2;
		wait_done();
		trigger_select = TRIG_AGC_LOCK_TO_UNLOCK;
		tick(gap_strobe());
		gpio_status.gain = 7'd20; // lock unchanged
		run(8);
		gpio_status.lock = 1'b0;
		acc_cyc = cyc + 2;
		wait_done();

		// room check at the exact boundary
		pack_two_iq = 1'b1;
		trigger_select = TRIG_FCS_OR_FREE;
		pre_trigger_len = 14'd20;
		iq_len_target = 14'd20;
		m_axis_data_count = 14'(MAX_NUM_DMA_SYMBOL_UDP - 20);
		fcs_event(1'b1, 1'b0);
		run(12);
		m_axis_data_count = 14'(MAX_NUM_DMA_SYMBOL_UDP - 21);
		fcs_event(1'b1, 1'b1);
		wait_done();
		m_axis_data_count = '0;

		// tx source with external start
		source_select = SRC_TX_INTF;
		trigger_select = TRIG_FCS_OK;
		run(30);
		m_axis_start_ext_trigger = 1'b1;
		@(negedge clk);
		compare("m_axis_start_1trans", m_axis_start_1trans, 1'b1);
		tick(gap_strobe());
		m_axis_start_ext_trigger = 1'b0;
		@(negedge clk);
		compare("m_axis_start_1trans", m_axis_start_1trans, 1'b0);
		fcs_event(1'b1, 1'b1);
		wait_done();
		source_select = SRC_RX;

		// auto start and then everything gated off
		start_mode = START_AUTO;
		axi_awaddr_core = 5'd3; // some other register
		start_pulse_check(1'b0);
		axi_awaddr_core = LEN_REG_ADDR;
		start_pulse_check(1'b1);
		fcs_event(1'b1, 1'b1);
		wait_done();
		start_mode = START_OFF;
		start_pulse_check(1'b0);
		fcs_event(1'b1, 1'b0);
		run(4 * MAX_LEN + 16);

		if (exp_q.size() != 0) begin
			$display("%0d expected words never came out of the DUT", exp_q.size());
			errors++;
		end
		if (errors == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "run ended with errors");
		end
	end

endmodule
